// File: verilog/bp_pkg.sv
package bp_pkg;

// word-aligned virtual address, bits 1:0 are always zero
typedef logic [31:0] virt_t;

typedef enum logic [1:0] {
	ControlFlow_None,
	ControlFlow_Branch,
	ControlFlow_Jump,
	ControlFlow_JumpReg
} cf_t;

// 2-bit saturating counter, msb set means taken
typedef logic [1:0] counter_t;

// default total entries, half of them in each bank
localparam int BP_ENTRIES = 64;

localparam int ICACHE_LINE_BYTES = 32;
localparam int ICACHE_OFFSET_BITS = $clog2(ICACHE_LINE_BYTES);

// weakly not taken
localparam counter_t COUNTER_RESET = 2'b01;

// branch resolved in execute
typedef struct packed {
	logic     valid;
	virt_t    pc;
	virt_t    target;
	cf_t      cf;
	logic     taken;
	counter_t counter;
} branch_resolved_t;

// decode found a predicted word that is not control flow
typedef struct packed {
	logic  valid;
	virt_t pc;
} presolved_branch_t;

// prediction handed to fetch
typedef struct packed {
	logic     valid;
	virt_t    target;
	cf_t      cf;
	logic     taken;
	counter_t counter;
} branch_predict_t;

// read-out of one btb slot
typedef struct packed {
	cf_t   cf;
	virt_t target;
} btb_predict_t;

endpackage

// File: verilog/bp_update_if.sv
`timescale 1ns/1ns

interface bp_update_if import bp_pkg::*; ();

// separate strobes for the two tables, shared payload
logic     btb_valid;
logic     bht_valid;
virt_t    pc;
virt_t    target;
cf_t      cf;
logic     taken;
counter_t counter;

modport source (
	output btb_valid, bht_valid, pc, target, cf, taken, counter
);

// cf is seen by the bht only for checking
modport bht (
	input bht_valid, pc, cf, taken, counter
);

modport btb (
	input btb_valid, pc, target, cf
);

endinterface

// File: verilog/bht.sv
`timescale 1ns/1ns

module bht import bp_pkg::*; #(
	parameter int SIZE = BP_ENTRIES
)(
	input  logic           clk,
	input  logic           rst,

	// fetch address, read every cycle
	input  virt_t          vaddr,

	// counter write-back from resolved branches
	bp_update_if.bht       upd,

	// one counter per slot, valid one cycle after vaddr
	output counter_t [1:0] predict
);

localparam int BANK_ENTRIES = SIZE / 2;
localparam int IDX_W = $clog2(BANK_ENTRIES);

counter_t cnt_mem [2][BANK_ENTRIES];

logic [IDX_W-1:0] rd_idx;
logic [IDX_W-1:0] wr_idx;
logic             wr_bank;
counter_t         wr_cnt;

// reset sweep state
logic [IDX_W-1:0] clr_idx;
logic             clr_busy;

// bank is picked by pc[2], the index sits right above it
assign rd_idx  = vaddr[IDX_W + 2 : 3];
assign wr_idx  = upd.pc[IDX_W + 2 : 3];
assign wr_bank = upd.pc[2];

// saturating step of the counter that was predicted with
always_comb begin
	wr_cnt = upd.counter;
	if (upd.taken) begin
		if (upd.counter != 2'b11) begin
			wr_cnt = upd.counter + 2'd1;
		end
	end else begin
		if (upd.counter != 2'b00) begin
			wr_cnt = upd.counter - 2'd1;
		end
	end
end

// one entry per bank is cleared each cycle until the whole table is done
always_ff @(posedge clk) begin
	if (rst) begin
		clr_idx  <= '0;
		clr_busy <= 1'b1;
	end else if (clr_busy) begin
		clr_idx <= clr_idx + 1'b1;
		if (&clr_idx) begin
			clr_busy <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (clr_busy) begin
		cnt_mem[0][clr_idx] <= COUNTER_RESET;
		cnt_mem[1][clr_idx] <= COUNTER_RESET;
	end else if (upd.bht_valid) begin
		cnt_mem[wr_bank][wr_idx] <= wr_cnt;
	end
end

// registered read, a write in the same cycle is not visible yet
always_ff @(posedge clk) begin
	predict[0] <= cnt_mem[0][rd_idx];
	predict[1] <= cnt_mem[1][rd_idx];
end

// only conditional branches carry a direction worth counting
assert property (@(posedge clk) disable iff (rst)
	upd.bht_valid |-> upd.cf == ControlFlow_Branch)
	else $error("bht written for a non-branch cf %0d", upd.cf);

endmodule

// File: verilog/btb.sv
`timescale 1ns/1ns

module btb import bp_pkg::*; #(
	parameter int SIZE = BP_ENTRIES
)(
	input  logic               clk,
	input  logic               rst,

	// fetch address, read every cycle
	input  virt_t              vaddr,

	// decode-time misprediction, drops the entry
	input  presolved_branch_t  presolved_branch,

	// training from resolved control flow
	bp_update_if.btb           upd,

	// one entry per slot, valid one cycle after vaddr
	output btb_predict_t [1:0] predict
);

localparam int BANK_ENTRIES = SIZE / 2;
localparam int IDX_W = $clog2(BANK_ENTRIES);
localparam int TAG_W = 32 - IDX_W - 3;

typedef logic [TAG_W-1:0] tag_t;

// entry storage, only the valid bits are cleared on reset
logic [BANK_ENTRIES-1:0] ent_valid [2];
tag_t                    ent_tag [2][BANK_ENTRIES];
virt_t                   ent_target [2][BANK_ENTRIES];
cf_t                     ent_cf [2][BANK_ENTRIES];

logic [IDX_W-1:0] rd_idx;
tag_t             rd_tag_in;
logic [IDX_W-1:0] wr_idx;
tag_t             wr_tag;
logic             wr_bank;
logic [IDX_W-1:0] inv_idx;
logic             inv_bank;

// registered read-out, tag compare happens afterwards
logic [1:0] rd_valid;
tag_t       rd_tag [2];
virt_t      rd_target [2];
cf_t        rd_cf [2];
tag_t       req_tag;

assign rd_idx    = vaddr[IDX_W + 2 : 3];
assign rd_tag_in = vaddr[31 : IDX_W + 3];
assign wr_idx    = upd.pc[IDX_W + 2 : 3];
assign wr_tag    = upd.pc[31 : IDX_W + 3];
assign wr_bank   = upd.pc[2];
assign inv_idx   = presolved_branch.pc[IDX_W + 2 : 3];
assign inv_bank  = presolved_branch.pc[2];

// training comes last so it wins over a clear of the same entry
always_ff @(posedge clk) begin
	if (rst) begin
		ent_valid[0] <= '0;
		ent_valid[1] <= '0;
	end else begin
		if (presolved_branch.valid) begin
			ent_valid[inv_bank][inv_idx] <= 1'b0;
		end
		if (upd.btb_valid) begin
			ent_valid[wr_bank][wr_idx] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (upd.btb_valid) begin
		ent_tag[wr_bank][wr_idx]    <= wr_tag;
		ent_target[wr_bank][wr_idx] <= upd.target;
		ent_cf[wr_bank][wr_idx]     <= upd.cf;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		rd_valid <= '0;
	end else begin
		rd_valid[0] <= ent_valid[0][rd_idx];
		rd_valid[1] <= ent_valid[1][rd_idx];
	end
end

always_ff @(posedge clk) begin
	req_tag <= rd_tag_in;
	for (int b = 0; b < 2; b++) begin
		rd_tag[b]    <= ent_tag[b][rd_idx];
		rd_target[b] <= ent_target[b][rd_idx];
		rd_cf[b]     <= ent_cf[b][rd_idx];
	end
end

// a miss or an empty entry looks like no control flow
always_comb begin
	for (int b = 0; b < 2; b++) begin
		predict[b].target = rd_target[b];
		if (rd_valid[b] && rd_tag[b] == req_tag) begin
			predict[b].cf = rd_cf[b];
		end else begin
			predict[b].cf = ControlFlow_None;
		end
	end
end

// execute only resolves real control flow, None would look like a miss
assert property (@(posedge clk) disable iff (rst)
	upd.btb_valid |-> upd.cf != ControlFlow_None)
	else $error("btb trained with cf None");

endmodule

// File: verilog/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor import bp_pkg::*; #(
	parameter int SIZE = BP_ENTRIES
)(
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,

	// fetch pc of this cycle and of the one before
	input  virt_t             pc_cur,
	input  virt_t             pc_prev,

	// training from execute
	input  branch_resolved_t  resolved_branch,

	// invalidation from decode
	input  presolved_branch_t presolved_branch,

	// prediction for the pair fetched one cycle earlier
	output branch_predict_t   prediction,
	output logic [1:0]        prediction_sel
);

bp_update_if upd ();

// table read-outs, live and held over a stall
counter_t [1:0]     bht_rd;
counter_t [1:0]     bht_hold;
counter_t [1:0]     bht_eff;
btb_predict_t [1:0] btb_rd;
btb_predict_t [1:0] btb_hold;
btb_predict_t [1:0] btb_eff;

logic         pipe_flush;
logic         pipe_stall;
logic         sel;
logic         line_end;
btb_predict_t btb_sel;
counter_t     bht_sel;

// copy of the last read-out taken while fetch was moving
always_ff @(posedge clk) begin
	if (!pipe_stall) begin
		bht_hold <= bht_rd;
		btb_hold <= btb_rd;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		pipe_flush <= 1'b0;
		pipe_stall <= 1'b0;
	end else begin
		pipe_stall <= stall;
		if (!stall) begin
			pipe_flush <= flush;
		end
	end
end

// held copy covers the stall and the first cycle after it
assign bht_eff = pipe_stall ? bht_hold : bht_rd;
assign btb_eff = pipe_stall ? btb_hold : btb_rd;

// odd word fetched: only slot 1 belongs to this fetch
always_comb begin
	if (pc_prev[2]) begin
		sel = 1'b1;
	end else begin
		sel = btb_eff[0].cf == ControlFlow_None;
	end
end

assign btb_sel        = btb_eff[sel];
assign bht_sel        = bht_eff[sel];
assign prediction_sel = sel ? 2'b10 : 2'b01;

// last word of the line, its delay slot lives in the next line
assign line_end = &pc_prev[ICACHE_OFFSET_BITS - 1 : 2];

always_comb begin
	prediction.valid   = btb_sel.cf != ControlFlow_None;
	prediction.target  = btb_sel.target;
	prediction.cf      = btb_sel.cf;
	prediction.counter = bht_sel;
	// jumps are always taken
	if (btb_sel.cf == ControlFlow_Branch) begin
		prediction.taken = bht_sel[1];
	end else begin
		prediction.taken = 1'b1;
	end
	if (line_end || pipe_flush) begin
		prediction.valid = 1'b0;
	end
end

// every resolved control flow trains the btb
assign upd.btb_valid = resolved_branch.valid;
// only conditional branches train the counters
assign upd.bht_valid = resolved_branch.valid && resolved_branch.cf == ControlFlow_Branch;
assign upd.pc        = resolved_branch.pc;
assign upd.target    = resolved_branch.target;
assign upd.cf        = resolved_branch.cf;
assign upd.taken     = resolved_branch.taken;
assign upd.counter   = resolved_branch.counter;

bht #(
	.SIZE ( SIZE )
) u_bht (
	.clk,
	.rst,
	.vaddr   ( pc_cur ),
	.upd     ( upd    ),
	.predict ( bht_rd )
);

btb #(
	.SIZE ( SIZE )
) u_btb (
	.clk,
	.rst,
	.vaddr            ( pc_cur           ),
	.presolved_branch ( presolved_branch ),
	.upd              ( upd              ),
	.predict          ( btb_rd           )
);

assert property (@(posedge clk) disable iff (rst) $onehot(prediction_sel))
	else $error("prediction_sel not one-hot: %b", prediction_sel);

endmodule

// File: verilog/bp_top.sv
`timescale 1ns/1ns

module bp_top import bp_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       stall,
	input  logic       flush,
	input  virt_t      pc_cur,
	input  virt_t      pc_prev,

	// resolved branch from execute
	input  logic       res_valid,
	input  virt_t      res_pc,
	input  virt_t      res_target,
	input  cf_t        res_cf,
	input  logic       res_taken,
	input  counter_t   res_counter,

	// presolved misprediction from decode
	input  logic       pre_valid,
	input  virt_t      pre_pc,

	output logic       pred_valid,
	output virt_t      pred_target,
	output cf_t        pred_cf,
	output logic       pred_taken,
	output counter_t   pred_counter,
	output logic [1:0] pred_sel
);

branch_resolved_t  resolved;
presolved_branch_t presolved;
branch_predict_t   prediction;

assign resolved  = '{res_valid, res_pc, res_target, res_cf, res_taken, res_counter};
assign presolved = '{pre_valid, pre_pc};

assign pred_valid   = prediction.valid;
assign pred_target  = prediction.target;
assign pred_cf      = prediction.cf;
assign pred_taken   = prediction.taken;
assign pred_counter = prediction.counter;

branch_predictor #(
	.SIZE ( BP_ENTRIES )
) u_branch_predictor (
	.clk,
	.rst,
	.stall,
	.flush,
	.pc_cur,
	.pc_prev,
	.resolved_branch  ( resolved   ),
	.presolved_branch ( presolved  ),
	.prediction       ( prediction ),
	.prediction_sel   ( pred_sel   )
);

endmodule

// File: bench/bp_tb_table.svh
// columns: pc_cur, {stall, flush}, resolved cf (cf_no means no update), update pc,
// resolved target, {taken, counter}, presolved valid, check (0 none, 1 miss, 2 hit),
// expected target, expected cf, expected {taken, counter}, expected sel
// a target with its low two bits set names an lfsr target slot
localparam int N_STEPS = 25;

step_t steps [N_STEPS] = '{
	// empty btb, first entries trained alongside
	'{32'h1000, 2'b00, cf_j,  32'h1000, 32'h1,    3'b101, '0, 2'd1, 32'h0,    cf_no, 3'b000, 2'b10},
	'{32'h1024, 2'b00, cf_br, 32'h1024, 32'h1100, 3'b011, '0, 2'd1, 32'h0,    cf_no, 3'b000, 2'b10},
	'{32'h3000, 2'b00, cf_j,  32'h10c0, 32'h3,    3'b101, '0, 2'd0, 32'h0,    cf_no, 3'b000, 2'b00},
	'{32'h3000, 2'b00, cf_br, 32'h10c4, 32'h2400, 3'b101, '0, 2'd0, 32'h0,    cf_no, 3'b000, 2'b00},
	// slot selection
	'{32'h1000, 2'b00, cf_j,  32'h105c, 32'h5000, 3'b101, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	'{32'h1020, 2'b00, cf_br, 32'h1040, 32'h6000, 3'b101, '0, 2'd2, 32'h1100, cf_br, 3'b110, 2'b10},
	'{32'h10c0, 2'b00, cf_j,  32'h1088, 32'h2,    3'b101, '0, 2'd2, 32'h3,    cf_j,  3'b101, 2'b01},
	'{32'h10c4, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h2400, cf_br, 3'b110, 2'b10},
	// hit in slot 1, then the same word as last of the line
	'{32'h1058, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h5000, cf_j,  3'b101, 2'b10},
	'{32'h105c, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd1, 32'h0,    cf_no, 3'b000, 2'b10},
	// flush drops one prediction
	'{32'h1000, 2'b01, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd1, 32'h0,    cf_no, 3'b000, 2'b01},
	// counter training 10 -> 01 -> 11
	'{32'h1040, 2'b00, cf_br, 32'h1040, 32'h6000, 3'b010, '0, 2'd2, 32'h6000, cf_br, 3'b110, 2'b01},
	'{32'h1040, 2'b00, cf_br, 32'h1040, 32'h6000, 3'b111, '0, 2'd2, 32'h6000, cf_br, 3'b001, 2'b01},
	'{32'h1040, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h6000, cf_br, 3'b111, 2'b01},
	// stall holds the read-out from before it
	'{32'h1040, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h6000, cf_br, 3'b111, 2'b01},
	'{32'h1000, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	'{32'h2000, 2'b10, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	'{32'h2008, 2'b10, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	'{32'h2010, 2'b10, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	'{32'h2000, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd1, 32'h0,    cf_no, 3'b000, 2'b10},
	'{32'h1000, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h1,    cf_j,  3'b101, 2'b01},
	// presolved clear, then clear and retrain together
	'{32'h1088, 2'b00, cf_no, 32'h1088, 32'h0,    3'b000, '1, 2'd2, 32'h2,    cf_j,  3'b101, 2'b01},
	'{32'h1088, 2'b00, cf_j,  32'h1088, 32'h2,    3'b101, '1, 2'd1, 32'h0,    cf_no, 3'b000, 2'b10},
	'{32'h1088, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd2, 32'h2,    cf_j,  3'b101, 2'b01},
	'{32'h3000, 2'b00, cf_no, 32'h0,    32'h0,    3'b000, '0, 2'd0, 32'h0,    cf_no, 3'b000, 2'b00}
};

// File: bench/bp_tb.sv
`timescale 1ns/1ns

module bp_tb import bp_pkg::*; ();

localparam int CLK_PERIOD = 8;
// reset itself plus the bht clear sweep over one bank
localparam int RESET_CYCLES = 3 + BP_ENTRIES / 2;

localparam cf_t cf_no = ControlFlow_None;
localparam cf_t cf_br = ControlFlow_Branch;
localparam cf_t cf_j  = ControlFlow_Jump;

typedef struct packed {
	virt_t      pc;
	logic [1:0] ctl;
	cf_t        res_cf;
	virt_t      upd_pc;
	virt_t      res_target;
	logic [2:0] res_bits;
	logic       pre;
	logic [1:0] chk;
	virt_t      e_target;
	cf_t        e_cf;
	logic [2:0] e_bits;
	logic [1:0] e_sel;
} step_t;

`include "bp_tb_table.svh"

localparam int CYCLE_LIMIT = 2 * N_STEPS + RESET_CYCLES;

logic       clk;
logic       rst;
logic       stall;
logic       flush;
virt_t      pc_cur;
virt_t      pc_prev;
logic       res_valid;
virt_t      res_pc;
virt_t      res_target;
cf_t        res_cf;
logic       res_taken;
counter_t   res_counter;
logic       pre_valid;
virt_t      pre_pc;
logic       pred_valid;
virt_t      pred_target;
cf_t        pred_cf;
logic       pred_taken;
counter_t   pred_counter;
logic [1:0] pred_sel;

logic [31:0] lfsr;
virt_t       rnd_target [4];
int          cur_step;
int          cycles = 0;

bp_top u_bp_top (.*);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic fail_run(string why);
	$display("%s", why);
	$display("Something failed");
	$fatal(1);
endtask

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles > CYCLE_LIMIT) begin
		fail_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
	end
end

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h80200003;
	end
	return s >> 1;
endfunction

// one lfsr step per target bit, word aligned
task automatic random_target(output virt_t t);
	t = '0;
	for (int i = 2; i < 32; i++) begin
		lfsr = lfsr_next(lfsr);
		t[i] = lfsr[0];
	end
endtask

function automatic virt_t pick_target(input virt_t t);
	if (t[1:0] != 2'b00) begin
		return rnd_target[t[1:0]];
	end
	return t;
endfunction

task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
	if (got !== want) begin
		fail_run($sformatf("Error %s got 0x%0h expected 0x%0h at step %0d",
			name, got, want, cur_step));
	end
endtask

task automatic drive_step(input step_t s, input virt_t prev);
	pc_cur      = s.pc;
	pc_prev     = prev;
	stall       = s.ctl[1];
	flush       = s.ctl[0];
	res_valid   = s.res_cf != cf_no;
	res_pc      = s.upd_pc;
	res_target  = pick_target(s.res_target);
	res_cf      = s.res_cf;
	res_taken   = s.res_bits[2];
	res_counter = s.res_bits[1:0];
	pre_valid   = s.pre;
	pre_pc      = s.upd_pc;
endtask

// target and kind only mean something on a hit
task automatic check_step(input step_t s);
	if (s.chk != 2'd0) begin
		check_value("pred_valid", 32'(pred_valid), 32'(s.chk == 2'd2));
		check_value("pred_sel", 32'(pred_sel), 32'(s.e_sel));
		if (s.chk == 2'd2) begin
			check_value("pred_target", pred_target, pick_target(s.e_target));
			check_value("pred_cf", 32'(pred_cf), 32'(s.e_cf));
			check_value("pred_taken", 32'(pred_taken), 32'(s.e_bits[2]));
			check_value("pred_counter", 32'(pred_counter), 32'(s.e_bits[1:0]));
		end
	end
endtask

initial begin
	rst         = 1'b1;
	stall       = 1'b0;
	flush       = 1'b0;
	pc_cur      = '0;
	pc_prev     = '0;
	res_valid   = 1'b0;
	res_pc      = '0;
	res_target  = '0;
	res_cf      = cf_no;
	res_taken   = 1'b0;
	res_counter = '0;
	pre_valid   = 1'b0;
	pre_pc      = '0;
	lfsr        = 32'habe36123;
	rnd_target[0] = '0;
	for (int i = 1; i < 4; i++) begin
		random_target(rnd_target[i]);
	end

	repeat (3) @(negedge clk);
	rst = 1'b0;
	repeat (RESET_CYCLES - 3) @(negedge clk);

	// prediction of step k shows up once pc_prev carries its pc
	for (int k = 0; k < N_STEPS; k++) begin
		@(negedge clk);
		drive_step(steps[k], (k == 0) ? 32'h0 : steps[k - 1].pc);
		#1;
		if (k > 0) begin
			cur_step = k - 1;
			check_step(steps[k - 1]);
		end
	end

	$display("Everything OK");
	$finish;
end

endmodule

// File: files.f
+incdir+bench
verilog/bp_pkg.sv
verilog/bp_update_if.sv
verilog/bht.sv
verilog/btb.sv
verilog/branch_predictor.sv
verilog/bp_top.sv
bench/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the branch predictor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module bp_tb -f files.f -o bp_tb_sim
./obj_dir/bp_tb_sim 2>&1 | tee sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
